//--- Makefile
# Verilator build and run for the pipelined MIPS core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert \
		--top-module pipeLineCPU_tb \
		-f pipeLineCPU.f \
		--Mdir obj_dir -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

//--- pipeLineCPU.f
src/mipsPkg.sv
src/fetchStage.sv
src/pipeReg.sv
src/decodeStage.sv
src/executeStage.sv
src/pipeLineCPU.sv
tb/pipeLineCPU_props.sv
tb/pipeLineCPU_tb.sv

//--- src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import mipsPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  ifIdT    ifId,
    input  regAddrT exLoadDest,
    input  logic    exIsLoad,
    input  memWbT   wb,
    output idExT    idEx,
    output logic    stall
);

    instrT       fields;
    logic [15:0] imm16;
    ctrlT        ctrl;
    regAddrT     dest;
    logic        zeroExt;
    logic        usesRs;
    logic        usesRt;
    wordT        rsVal;
    wordT        rtVal;
    wordT        immExt;
    wordT        regFile [32];

    assign fields = ifId.instr;
    assign imm16  = {fields.rd, fields.shamt, fields.funct};

    // ~~~~~~~~~~~~~~~~~~~~
    // control decode

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        dest       = fields.rt;
        zeroExt    = 1'b0;
        usesRs     = 1'b1;
        usesRt     = 1'b0;
        case (fields.opcode)
            opRType: begin
                ctrl.regWrite = 1'b1;
                dest          = fields.rd;
                usesRt        = 1'b1;
                case (fields.funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:  ctrl.aluOp = aluAnd;
                    fnOr:   ctrl.aluOp = aluOr;
                    fnSlt:  ctrl.aluOp = aluSlt;
                    fnSll: begin
                        ctrl.aluOp = aluSll;
                        usesRs     = 1'b0;  // shifts rt only
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opAddiu: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opOri: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluOr;
                zeroExt        = 1'b1;
            end
            opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluLui;
                usesRs         = 1'b0;
            end
            opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                usesRt         = 1'b1;  // store data
            end
            opBeq: begin
                ctrl.branchEq = 1'b1;
                usesRt        = 1'b1;
            end
            opBne: begin
                ctrl.branchNe = 1'b1;
                usesRt        = 1'b1;
            end
            opJ: begin
                ctrl.jump = 1'b1;
                usesRs    = 1'b0;
            end
            opJal: begin
                ctrl.jump      = 1'b1;
                ctrl.linkToReg = 1'b1;
                ctrl.regWrite  = 1'b1;
                dest           = 5'd31;  // $ra
                usesRs         = 1'b0;
            end
            default: usesRs = 1'b0;  // unknown op runs as a bubble
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // register file, written from writeback

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (wb.regWrite && wb.dest != '0) begin
            regFile[wb.dest] <= wb.writeData;
        end
    end

    // write-first, same-cycle writeback is visible
    always_comb begin
        rsVal = regFile[fields.rs];
        if (fields.rs == '0) begin
            rsVal = '0;
        end else if (wb.regWrite && wb.dest == fields.rs) begin
            rsVal = wb.writeData;
        end
    end

    always_comb begin
        rtVal = regFile[fields.rt];
        if (fields.rt == '0) begin
            rtVal = '0;
        end else if (wb.regWrite && wb.dest == fields.rt) begin
            rtVal = wb.writeData;
        end
    end

    assign immExt = zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

    // load in execute feeding a source here
    assign stall = exIsLoad && exLoadDest != '0 &&
                   ((usesRs && exLoadDest == fields.rs) || (usesRt && exLoadDest == fields.rt));

    always_comb begin
        idEx.ctrl      = ctrl;
        idEx.pc4       = ifId.pc4;
        idEx.rsVal     = rsVal;
        idEx.rtVal     = rtVal;
        idEx.rs        = fields.rs;
        idEx.rt        = fields.rt;
        idEx.dest      = dest;
        idEx.imm       = immExt;
        idEx.shamt     = fields.shamt;
        idEx.jumpField = ifId.instr[25:0];
    end

endmodule

//--- src/executeStage.sv
`timescale 1ns/1ps

module executeStage import mipsPkg::*; (
    input  idExT  idEx,
    input  exMemT memFwd,
    input  memWbT wbFwd,
    input  wordT  memReadData,
    output exMemT exMem,
    output memWbT memWb,
    output logic  redirect,
    output wordT  redirectPc
);

    wordT memFwdVal;
    logic fwdMemA;
    logic fwdMemB;
    logic fwdWbA;
    logic fwdWbB;
    wordT opA;
    wordT opB;
    wordT aluB;
    wordT aluResult;
    logic regsEqual;
    logic takeBranch;
    wordT branchTarget;
    wordT jumpTarget;

    // ~~~~~~~~~~~~~~~~~~~~
    // forwarding

    assign memFwdVal = memFwd.linkToReg ? memFwd.linkVal : memFwd.aluResult;

    // load data is not ready in memory stage, stall covers that case
    assign fwdMemA = memFwd.regWrite && !memFwd.memRead &&
                     memFwd.dest != '0 && memFwd.dest == idEx.rs;
    assign fwdMemB = memFwd.regWrite && !memFwd.memRead &&
                     memFwd.dest != '0 && memFwd.dest == idEx.rt;
    assign fwdWbA  = wbFwd.regWrite && wbFwd.dest != '0 && wbFwd.dest == idEx.rs;
    assign fwdWbB  = wbFwd.regWrite && wbFwd.dest != '0 && wbFwd.dest == idEx.rt;

    always_comb begin
        if (fwdMemA) begin
            opA = memFwdVal;  // newest wins
        end else if (fwdWbA) begin
            opA = wbFwd.writeData;
        end else begin
            opA = idEx.rsVal;
        end
    end

    always_comb begin
        if (fwdMemB) begin
            opB = memFwdVal;
        end else if (fwdWbB) begin
            opB = wbFwd.writeData;
        end else begin
            opB = idEx.rtVal;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // ALU

    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  aluResult = opA + aluB;
            aluSub:  aluResult = opA - aluB;
            aluAnd:  aluResult = opA & aluB;
            aluOr:   aluResult = opA | aluB;
            aluSlt:  aluResult = wordT'($signed(opA) < $signed(aluB));
            aluSll:  aluResult = aluB << idEx.shamt;
            aluLui:  aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = opA + aluB;
        endcase
    end

    // branch and jump resolution
    assign regsEqual    = opA == opB;
    assign takeBranch   = (idEx.ctrl.branchEq && regsEqual) ||
                          (idEx.ctrl.branchNe && !regsEqual);
    assign branchTarget = idEx.pc4 + {idEx.imm[29:0], 2'b00};
    assign jumpTarget   = {idEx.pc4[31:28], idEx.jumpField, 2'b00};
    assign redirect     = takeBranch || idEx.ctrl.jump;
    assign redirectPc   = idEx.ctrl.jump ? jumpTarget : branchTarget;

    always_comb begin
        exMem.regWrite  = idEx.ctrl.regWrite;
        exMem.memRead   = idEx.ctrl.memRead;
        exMem.memWrite  = idEx.ctrl.memWrite;
        exMem.memToReg  = idEx.ctrl.memToReg;
        exMem.linkToReg = idEx.ctrl.linkToReg;
        exMem.aluResult = aluResult;
        exMem.storeData = opB;  // forwarded rt
        exMem.dest      = idEx.dest;
        exMem.linkVal   = idEx.pc4;
    end

    // memory stage select, load data or result
    always_comb begin
        memWb.regWrite  = memFwd.regWrite;
        memWb.dest      = memFwd.dest;
        memWb.writeData = memFwd.memToReg ? memReadData : memFwdVal;
    end

endmodule

//--- src/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import mipsPkg::*; #(
    parameter wordT resetPc = 32'h0000_0000
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic redirect,
    input  wordT redirectPc,
    output wordT pc,
    output wordT pc4
);

    assign pc4 = pc + 32'd4;

    // redirect beats stall, stall beats advance
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (redirect) begin
            pc <= redirectPc;  // taken branch or jump from execute
        end else if (!stall) begin
            pc <= pc4;
        end
    end

endmodule

//--- src/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // ~~~~~~~~~~~~~~~~~~~~
    // instruction fields

    typedef struct packed {
        logic [5:0] opcode;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instrT;

    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    localparam logic [5:0] fnSll   = 6'h00;  // all-zero word is sll $0 nop
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnSlt   = 6'h2a;

    // ~~~~~~~~~~~~~~~~~~~~
    // control and stage payloads

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluLui
    } aluOpT;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  linkToReg;
        logic  aluSrcImm;
        logic  branchEq;
        logic  branchNe;
        logic  jump;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        wordT  pc4;
        instrT instr;
    } ifIdT;

    typedef struct packed {
        ctrlT        ctrl;
        wordT        pc4;
        wordT        rsVal;
        wordT        rtVal;
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     dest;
        wordT        imm;
        logic [4:0]  shamt;
        logic [25:0] jumpField;
    } idExT;

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    memToReg;
        logic    linkToReg;
        wordT    aluResult;
        wordT    storeData;
        regAddrT dest;
        wordT    linkVal;
    } exMemT;

    typedef struct packed {
        logic    regWrite;
        regAddrT dest;
        wordT    writeData;  // load data already picked
    } memWbT;

endpackage

//--- src/pipeLineCPU.sv
`timescale 1ns/1ps

module pipeLineCPU import mipsPkg::*; #(
    parameter wordT resetPc = 32'h0000_0000
) (
    input  logic clk,
    input  logic reset,
    input  wordT inst_in,
    input  wordT Data_in,
    output logic mem_w,
    output wordT Addr_out,
    output wordT PC_out,
    output wordT Data_out
);

    wordT  pc;
    wordT  pc4;
    logic  stall;
    logic  redirect;
    wordT  redirectPc;
    ifIdT  ifIdD;
    ifIdT  ifIdQ;
    idExT  idExD;
    idExT  idExQ;
    exMemT exMemD;
    exMemT exMemQ;
    memWbT memWbD;
    memWbT memWbQ;

    // ~~~~~~~~~~~~~~~~~~~~
    // fetch

    fetchStage #(.resetPc(resetPc)) fetch0 (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .pc         (pc),
        .pc4        (pc4)
    );

    assign PC_out = pc;
    assign ifIdD  = '{pc4: pc4, instr: inst_in};

    pipeReg #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .reset(reset), .hold(stall), .flush(redirect), .d(ifIdD), .q(ifIdQ)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // decode and execute

    decodeStage decode0 (
        .clk        (clk),
        .reset      (reset),
        .ifId       (ifIdQ),
        .exLoadDest (idExQ.dest),
        .exIsLoad   (idExQ.ctrl.memRead),
        .wb         (memWbQ),
        .idEx       (idExD),
        .stall      (stall)
    );

    pipeReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .reset(reset), .hold(1'b0), .flush(stall || redirect), .d(idExD), .q(idExQ)
    );

    executeStage execute0 (
        .idEx        (idExQ),
        .memFwd      (exMemQ),
        .wbFwd       (memWbQ),
        .memReadData (Data_in),
        .exMem       (exMemD),
        .memWb       (memWbD),
        .redirect    (redirect),
        .redirectPc  (redirectPc)
    );

    pipeReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .reset(reset), .hold(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
    );

    // memory stage is just the ports
    assign Addr_out = exMemQ.aluResult;
    assign Data_out = exMemQ.storeData;
    assign mem_w    = exMemQ.memWrite;

    pipeReg #(.payloadT(memWbT)) memWbReg (
        .clk(clk), .reset(reset), .hold(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
    );

endmodule

//--- src/pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    hold,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // zero payload is a bubble, no write enables set
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

//--- tb/pipeLineCPU_props.sv
`timescale 1ns/1ps

module pipeLineCPU_props import mipsPkg::*; (
    input logic clk,
    input logic reset,
    input logic mem_w,
    input wordT Addr_out,
    input wordT PC_out,
    input logic stall,
    input logic redirect
);

    // ~~~~~~~~~~~~~~~~~~~~
    // memory ports

    memQuietAfterReset: assert property (@(posedge clk) reset |=> !mem_w)
        else $error("mem_w high in the cycle after reset");

    storeAligned: assert property (@(posedge clk) disable iff (reset)
        mem_w |-> Addr_out[1:0] == 2'b00)
        else $error("store address %h not word aligned", Addr_out);

    // ~~~~~~~~~~~~~~~~~~~~
    // fetch side

    pcAligned: assert property (@(posedge clk) disable iff (reset) PC_out[1:0] == 2'b00)
        else $error("PC_out %h not word aligned", PC_out);

    pcHeldOnStall: assert property (@(posedge clk) disable iff (reset)
        (stall && !redirect) |=> $stable(PC_out))  // load-use bubble
        else $error("PC_out moved during a stall");

endmodule

bind pipeLineCPU pipeLineCPU_props props0 (
    .clk      (clk),
    .reset    (reset),
    .mem_w    (mem_w),
    .Addr_out (Addr_out),
    .PC_out   (PC_out),
    .stall    (stall),
    .redirect (redirect)
);

//--- tb/pipeLineCPU_tb.sv
`timescale 1ns/1ps

module pipeLineCPU_tb import mipsPkg::*; ();

    localparam int   clkPeriod  = 100;
    localparam int   driveDelay = 1;
    localparam int   numRows    = 6;
    localparam int   progSlots  = 16;
    localparam int   storeSlots = 6;
    localparam wordT startPc    = 32'h0000_0040;

    logic clk;
    logic reset;
    wordT inst_in;
    wordT Data_in;
    logic mem_w;
    wordT Addr_out;
    wordT PC_out;
    wordT Data_out;

    wordT        imem [64];
    wordT        dmem [64];
    wordT        progTable [numRows][progSlots];
    int          progLen [numRows];
    int          budget [numRows];
    int          storeCount [numRows];
    wordT        expAddr [numRows][storeSlots];
    wordT        expData [numRows][storeSlots];
    wordT        gotAddr [$];
    wordT        gotData [$];
    logic [15:0] lfsr;
    bit          tableBuilt;

    pipeLineCPU #(.resetPc(startPc)) dut0 (
        .clk      (clk),
        .reset    (reset),
        .inst_in  (inst_in),
        .Data_in  (Data_in),
        .mem_w    (mem_w),
        .Addr_out (Addr_out),
        .PC_out   (PC_out),
        .Data_out (Data_out)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~
    // memory models

    assign inst_in = imem[PC_out[7:2]];
    assign Data_in = dmem[Addr_out[7:2]];

    // refilled with its address pattern while the core is in reset
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= 32'hDA7A_0000 | wordT'(i << 2);
            end
        end else if (mem_w) begin
            dmem[Addr_out[7:2]] <= Data_out;
        end
    end

    // stores are sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            gotAddr.delete();
            gotData.delete();
        end else if (mem_w) begin
            gotAddr.push_back(Addr_out);
            gotData.push_back(Data_out);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // encoders and random bits

    function automatic wordT rTypeWord(logic [5:0] funct, int rs, int rt, int rd, int sh);
        return {opRType, rs[4:0], rt[4:0], rd[4:0], sh[4:0], funct};
    endfunction

    function automatic wordT iTypeWord(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic wordT jTypeWord(logic [5:0] op, wordT target);
        return {op, target[27:2]};
    endfunction

    function automatic wordT slotPc(int slot);
        return startPc + wordT'(slot * 4);
    endfunction

    function automatic logic [15:0] lfsrStep(logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1
        end
        return n;
    endfunction

    task automatic randomBits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    task automatic addInstr(input int row, input wordT word);
        progTable[row][progLen[row]] = word;
        progLen[row] = progLen[row] + 1;
    endtask

    task automatic addStore(input int row, input wordT addr, input wordT data);
        expAddr[row][storeCount[row]] = addr;
        expData[row][storeCount[row]] = data;
        storeCount[row] = storeCount[row] + 1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus table

    task automatic buildTable();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        logic [15:0] bits;
        wordT        a;
        wordT        b;
        wordT        diff;
        foreach (progTable[r, s]) begin
            progTable[r][s] = '0;
        end
        foreach (progLen[r]) begin
            progLen[r]    = 0;
            storeCount[r] = 0;
        end
        // independent ALU ops
        addInstr(0, iTypeWord(opAddiu, 0, 1, 16'h1234));
        addInstr(0, iTypeWord(opAddiu, 0, 2, 16'h00F0));
        addInstr(0, iTypeWord(opAddiu, 0, 3, 16'hFFFB));  // -5
        addInstr(0, rTypeWord(fnAddu, 1, 2, 4, 0));
        addInstr(0, rTypeWord(fnSubu, 1, 2, 5, 0));
        addInstr(0, rTypeWord(fnAnd, 1, 2, 6, 0));
        addInstr(0, rTypeWord(fnOr, 1, 2, 7, 0));
        addInstr(0, rTypeWord(fnSlt, 3, 1, 8, 0));
        addInstr(0, rTypeWord(fnSll, 0, 2, 9, 4));
        for (int i = 0; i < 6; i++) begin
            addInstr(0, iTypeWord(opSw, 0, 4 + i, 16'h0080 + 16'(i * 4)));
        end
        addStore(0, 32'h80, 32'h0000_1324);
        addStore(0, 32'h84, 32'h0000_1144);
        addStore(0, 32'h88, 32'h0000_0030);
        addStore(0, 32'h8C, 32'h0000_12F4);
        addStore(0, 32'h90, 32'h0000_0001);
        addStore(0, 32'h94, 32'h0000_0F00);
        budget[0] = 25;
        // back-to-back dependencies
        addInstr(1, iTypeWord(opAddiu, 0, 1, 16'd5));
        addInstr(1, iTypeWord(opAddiu, 1, 2, 16'd3));
        addInstr(1, rTypeWord(fnAddu, 2, 1, 3, 0));
        addInstr(1, rTypeWord(fnSubu, 3, 2, 4, 0));
        addInstr(1, iTypeWord(opSw, 0, 4, 16'h0080));
        addInstr(1, rTypeWord(fnSll, 0, 4, 5, 2));
        addInstr(1, iTypeWord(opSw, 0, 5, 16'h0084));
        addInstr(1, iTypeWord(opSw, 0, 3, 16'h0088));
        addStore(1, 32'h80, 32'd5);
        addStore(1, 32'h84, 32'd20);
        addStore(1, 32'h88, 32'd13);
        budget[1] = 20;
        // load-use, word 0x40 holds its fill pattern
        addInstr(2, iTypeWord(opAddiu, 0, 2, 16'h0100));
        addInstr(2, iTypeWord(opLw, 0, 1, 16'h0040));
        addInstr(2, rTypeWord(fnAddu, 1, 2, 3, 0));
        addInstr(2, iTypeWord(opSw, 0, 3, 16'h0080));
        addInstr(2, iTypeWord(opLw, 0, 4, 16'h0080));
        addInstr(2, iTypeWord(opSw, 0, 4, 16'h0084));  // store data from a load
        addStore(2, 32'h80, 32'hDA7A_0040 + 32'h100);
        addStore(2, 32'h84, 32'hDA7A_0040 + 32'h100);
        budget[2] = 20;
        // branches and j
        addInstr(3, iTypeWord(opAddiu, 0, 1, 16'd7));
        addInstr(3, iTypeWord(opAddiu, 0, 2, 16'd7));
        addInstr(3, iTypeWord(opBeq, 1, 2, 16'd2));  // to slot 5
        addInstr(3, iTypeWord(opSw, 0, 1, 16'h0080));
        addInstr(3, iTypeWord(opSw, 0, 1, 16'h0084));
        addInstr(3, iTypeWord(opBne, 1, 2, 16'd2));
        addInstr(3, iTypeWord(opSw, 0, 2, 16'h0088));
        addInstr(3, jTypeWord(opJ, slotPc(10)));
        addInstr(3, iTypeWord(opSw, 0, 1, 16'h008C));
        addInstr(3, iTypeWord(opSw, 0, 1, 16'h0090));
        addInstr(3, iTypeWord(opAddiu, 0, 3, 16'h0055));
        addInstr(3, iTypeWord(opSw, 0, 3, 16'h0094));
        addStore(3, 32'h88, 32'd7);
        addStore(3, 32'h94, 32'h55);
        budget[3] = 24;
        // jal link and lui/ori constant
        addInstr(4, jTypeWord(opJal, slotPc(3)));
        addInstr(4, iTypeWord(opSw, 0, 0, 16'h0080));
        addInstr(4, iTypeWord(opSw, 0, 0, 16'h0084));
        addInstr(4, iTypeWord(opSw, 0, 31, 16'h0088));
        addInstr(4, iTypeWord(opLui, 0, 5, 16'hBEEF));
        addInstr(4, iTypeWord(opOri, 5, 5, 16'h8001));
        addInstr(4, iTypeWord(opSw, 0, 5, 16'h008C));
        addStore(4, 32'h88, slotPc(0) + 32'd4);
        addStore(4, 32'h8C, 32'hBEEF_8001);
        budget[4] = 20;
        // random immediates
        lfsr = 16'd17;
        randomBits(16, immA);
        randomBits(16, immB);
        randomBits(5, bits);
        randomBits(16, immC);
        addInstr(5, iTypeWord(opAddiu, 0, 1, immA));
        addInstr(5, iTypeWord(opAddiu, 0, 2, immB));
        addInstr(5, rTypeWord(fnSubu, 1, 2, 3, 0));
        addInstr(5, rTypeWord(fnSlt, 1, 2, 4, 0));
        addInstr(5, rTypeWord(fnSll, 0, 1, 5, int'(bits[4:0])));
        addInstr(5, iTypeWord(opAddiu, 3, 6, immC));
        for (int i = 0; i < 4; i++) begin
            addInstr(5, iTypeWord(opSw, 0, 3 + i, 16'h0080 + 16'(i * 4)));
        end
        a    = {{16{immA[15]}}, immA};
        b    = {{16{immB[15]}}, immB};
        diff = a - b;
        addStore(5, 32'h80, diff);
        addStore(5, 32'h84, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        addStore(5, 32'h88, a << bits[4:0]);
        addStore(5, 32'h8C, diff + {{16{immC[15]}}, immC});
        budget[5] = 22;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // checks

    task automatic reportFailure(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compareWord(input wordT got, input wordT exp, input string what);
        if (got !== exp) begin
            reportFailure($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic compareAddr(input wordT got, input wordT exp, input string what);
        if (got !== exp) begin
            reportFailure($sformatf("%s is address %h, expected %h", what, got, exp));
        end
    endtask

    task automatic runRow(input int row);
        @(posedge clk);
        #driveDelay reset = 1'b1;
        @(posedge clk);
        #driveDelay;
        foreach (imem[i]) begin
            imem[i] = '0;  // zero word is a nop
        end
        for (int s = 0; s < progLen[row]; s++) begin
            imem[int'(startPc[7:2]) + s] = progTable[row][s];
        end
        repeat (3) @(posedge clk);
        #driveDelay reset = 1'b0;
        compareAddr(PC_out, startPc, $sformatf("row %0d PC_out after reset", row));
        repeat (budget[row]) @(posedge clk);
        #driveDelay;
        if (gotAddr.size() != storeCount[row]) begin
            reportFailure($sformatf("row %0d made %0d stores, expected %0d",
                                    row, gotAddr.size(), storeCount[row]));
        end
        for (int i = 0; i < storeCount[row]; i++) begin
            compareAddr(gotAddr[i], expAddr[row][i], $sformatf("row %0d store %0d", row, i));
            compareWord(gotData[i], expData[row][i], $sformatf("row %0d store %0d", row, i));
        end
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        foreach (imem[i]) begin
            imem[i] = '0;
        end
        buildTable();
        tableBuilt = 1'b1;
        for (int row = 0; row < numRows; row++) begin
            runRow(row);
        end
        $display("sim passed");
        $finish;
    end

    // row budgets plus reset overhead and a margin
    initial begin : watchdog
        int limitCycles;
        wait (tableBuilt);
        limitCycles = 40;
        for (int r = 0; r < numRows; r++) begin
            limitCycles = limitCycles + budget[r] + 6;
        end
        #(limitCycles * clkPeriod);
        $display("timeout: the run did not finish within %0d cycles", limitCycles);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule
